// File: adc_ctrl/adc_seq.sv
// adc sequencer for the settling wait, converter reset, setup writes and periodic sample reads
module adc_seq
	import adc_pkg::*;
#(
	parameter int INIT_CYCLES   = 1048575,
	parameter int RESET_BITS    = 32,
	parameter int SAMPLE_PERIOD = 50000
)(
	input  logic     clk_sys,
	input  logic     rst_n,
	input  logic     cmd_busy,
	input  logic     cmd_done,
	input  sample_t  rsp,
	output ser_cmd_t cmd,
	output logic     cmd_start,
	output logic     cfg_done,
	output sample_t  cfg_readback,
	output logic     ad_vld,
	output sample_t  ad_data
);

	localparam int INIT_W   = $clog2(INIT_CYCLES + 1);
	localparam int PERIOD_W = $clog2(SAMPLE_PERIOD + 1);

	typedef enum logic [3:0] {
		S_INIT,
		S_RESET,
		S_WR_COMM,
		S_WR_CFG,
		S_WR_RDCMD,
		S_RD_CFG,
		S_WR_CONT,
		S_WAIT,
		S_SAMPLE
	} seq_state_t;

	seq_state_t state;
	logic [INIT_W-1:0] init_cnt;
	logic [PERIOD_W-1:0] period_cnt;
	logic init_fire;
	logic period_fire;
	logic cmd_end;

	function automatic ser_cmd_t make_cmd(ser_op_t op, logic [NBITS_W-1:0] nbits,
		logic [CMD_DATA_W-1:0] wdata);
		ser_cmd_t c;
		c.op    = op;
		c.nbits = nbits;
		c.wdata = wdata;
		return c;
	endfunction

	// --------------------------------------------------
	// counters
	// --------------------------------------------------

	assign init_fire   = (init_cnt == INIT_W'(INIT_CYCLES - 1));
	assign period_fire = (period_cnt == PERIOD_W'(SAMPLE_PERIOD - 1));

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			init_cnt <= '0;
		else if (state == S_INIT && !init_fire)
			init_cnt <= init_cnt + 1'b1;
		else
			init_cnt <= '0;
	end

	// keeps running through the read so starts stay evenly spaced
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			period_cnt <= '0;
		else if ((state != S_WAIT && state != S_SAMPLE) || period_fire)
			period_cnt <= '0;
		else
			period_cnt <= period_cnt + 1'b1;
	end

	// --------------------------------------------------
	// main fsm
	// --------------------------------------------------

	// only act on a finished command once the engine is free again
	assign cmd_end = cmd_done && !cmd_busy;

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= S_INIT;
			cmd_start <= 1'b0;
			cfg_done  <= 1'b0;
			ad_vld    <= 1'b0;
		end
		else
		begin
			cmd_start <= 1'b0;
			cfg_done  <= 1'b0;
			ad_vld    <= 1'b0;
			case (state)
				S_INIT:
					if (init_fire)
					begin
						state     <= S_RESET;
						cmd_start <= 1'b1;
					end
				S_RESET:
					if (cmd_end)
					begin
						state     <= S_WR_COMM;
						cmd_start <= 1'b1;
					end
				S_WR_COMM:
					if (cmd_end)
					begin
						state     <= S_WR_CFG;
						cmd_start <= 1'b1;
					end
				S_WR_CFG:
					if (cmd_end)
					begin
						state     <= S_WR_RDCMD;
						cmd_start <= 1'b1;
					end
				S_WR_RDCMD:
					if (cmd_end)
					begin
						state     <= S_RD_CFG;
						cmd_start <= 1'b1;
					end
				S_RD_CFG:
					if (cmd_end)
					begin
						state     <= S_WR_CONT;
						cmd_start <= 1'b1;
						cfg_done  <= 1'b1;
					end
				S_WR_CONT:
					if (cmd_end)
						state <= S_WAIT;
				S_WAIT:
					if (period_fire)
					begin
						state     <= S_SAMPLE;
						cmd_start <= 1'b1;
					end
				S_SAMPLE:
					if (cmd_end)
					begin
						state  <= S_WAIT;
						ad_vld <= 1'b1;
					end
				default:
					state <= S_INIT;
			endcase
		end
	end

	// command follows the state and is latched by the engine on cmd_start
	always_comb
	begin
		case (state)
			S_RESET:    cmd = make_cmd(OP_RESET, NBITS_W'(RESET_BITS), '0);
			S_WR_COMM:  cmd = make_cmd(OP_WRITE, 6'd8, {CFG_COMM_WR_CFG, 16'h0});
			S_WR_CFG:   cmd = make_cmd(OP_WRITE, 6'd24, CFG_WORD);
			S_WR_RDCMD: cmd = make_cmd(OP_WRITE, 6'd8, {CFG_COMM_RD_CFG, 16'h0});
			S_WR_CONT:  cmd = make_cmd(OP_WRITE, 6'd8, {CFG_COMM_CONT_RD, 16'h0});
			default:    cmd = make_cmd(OP_READ, NBITS_W'(SAMPLE_W), '0);
		endcase
	end

	// response capture
	always_ff @(posedge clk_sys)
	begin
		if (state == S_RD_CFG && cmd_end)
			cfg_readback <= rsp;
		if (state == S_SAMPLE && cmd_end)
			ad_data <= rsp;
	end

endmodule

// File: adc_ctrl/adc_serial.sv
// adc serial engine that syncs the bus clock, gates it toward the adc and shifts bits both ways
module adc_serial
	import adc_pkg::*;
(
	input  logic     clk_sys,
	input  logic     rst_n,
	input  logic     ad_clk_in,
	input  logic     ad_din,
	input  ser_cmd_t cmd,
	input  logic     cmd_start,
	output logic     ad_clk,
	output logic     ad_cfg,
	output logic     cmd_busy,
	output logic     cmd_done,
	output sample_t  rsp
);

	typedef enum logic [1:0] {
		E_IDLE,
		E_ARM,
		E_SHIFT
	} eng_state_t;

	eng_state_t state;
	logic [2:0] clk_sync;
	logic clk_rise;
	logic clk_fall;
	logic clk_en;
	ser_op_t op;
	logic [NBITS_W-1:0] nbits;
	logic [NBITS_W-1:0] bit_cnt;
	logic [CMD_DATA_W-1:0] shreg;
	logic last_bit;

	// --------------------------------------------------
	// clock sync and edge detect
	// --------------------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			clk_sync <= 3'b000;
		else
			clk_sync <= {clk_sync[1:0], ad_clk_in};
	end

	assign clk_rise = clk_sync[1] && !clk_sync[2];
	assign clk_fall = !clk_sync[1] && clk_sync[2];

	// held high unless enabled
	assign ad_clk = ad_clk_in | ~clk_en;

	assign last_bit = (bit_cnt == nbits - 1'b1);

	// --------------------------------------------------
	// control
	// --------------------------------------------------

	// enable only toggles on a rise event while ad_clk_in is still high
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= E_IDLE;
			clk_en   <= 1'b0;
			ad_cfg   <= 1'b0;
			cmd_busy <= 1'b0;
			cmd_done <= 1'b0;
			bit_cnt  <= '0;
		end
		else
		begin
			cmd_done <= 1'b0;
			case (state)
				E_IDLE:
					if (cmd_start)
					begin
						state    <= E_ARM;
						cmd_busy <= 1'b1;
						bit_cnt  <= '0;
					end
				E_ARM:
					if (clk_rise)
					begin
						state  <= E_SHIFT;
						clk_en <= 1'b1;
					end
				E_SHIFT:
				begin
					// new bit after each falling edge and a steady high line for reset
					if (clk_fall)
						ad_cfg <= (op == OP_RESET) | shreg[CMD_DATA_W-1];
					if (clk_rise)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit)
						begin
							state    <= E_IDLE;
							clk_en   <= 1'b0;
							ad_cfg   <= 1'b0;
							cmd_busy <= 1'b0;
							cmd_done <= 1'b1;
						end
					end
				end
				default:
					state <= E_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// data path
	// --------------------------------------------------

	always_ff @(posedge clk_sys)
	begin
		if (state == E_IDLE && cmd_start)
		begin
			op    <= cmd.op;
			nbits <= cmd.nbits;
			shreg <= (cmd.op == OP_WRITE) ? cmd.wdata : '0;
			rsp   <= '0;
		end
		else if (state == E_SHIFT)
		begin
			if (clk_fall)
				shreg <= {shreg[CMD_DATA_W-2:0], 1'b0};
			// adc drives din after the falling edge so it is stable at the rise
			if (clk_rise && op == OP_READ)
				rsp.data <= {rsp.data[SAMPLE_W-2:0], ad_din};
		end
	end

endmodule

// File: all.f
common/adc_pkg.sv
adc_ctrl/adc_serial.sv
adc_ctrl/adc_seq.sv
verilog/sample_avg.sv
verilog/adc_top.sv
test/adc_props.sv
test/adc_model.sv
test/tb_adc_top.sv

// File: common/adc_pkg.sv
// adc controller package with serial command types, the sample type and converter settings
package adc_pkg;

	// --------------------------------------------------
	// serial interface
	// --------------------------------------------------

	// clock count field wide enough for 32 clocks
	localparam int NBITS_W = 6;

	// payload width of a write command
	localparam int CMD_DATA_W = 24;

	typedef enum logic [1:0] {
		OP_RESET = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2
	} ser_op_t;

	// one bus operation with the write data in the top bits
	typedef struct packed {
		ser_op_t               op;
		logic [NBITS_W-1:0]    nbits;
		logic [CMD_DATA_W-1:0] wdata;
	} ser_cmd_t;

	// --------------------------------------------------
	// sample data
	// --------------------------------------------------

	localparam int SAMPLE_W = 24;

	typedef struct packed {
		logic [SAMPLE_W-1:0] data;
	} sample_t;

	// --------------------------------------------------
	// converter setup
	// --------------------------------------------------

	// comm byte so the next access writes the configuration register
	localparam logic [7:0] CFG_COMM_WR_CFG = 8'h10;

	// configuration register value
	localparam logic [23:0] CFG_WORD = 24'h000110;

	// comm byte so the next access reads the configuration register
	localparam logic [7:0] CFG_COMM_RD_CFG = 8'h50;

	// comm byte that enters continuous read of the data register
	localparam logic [7:0] CFG_COMM_CONT_RD = 8'h5C;

endpackage

// File: run.sh
#!/bin/sh
# compile and run the adc controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_top -f all.f -o sim_adc
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/sim_adc 2>&1)
run_status=$?
printf '%s\n' "$sim_output"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -q '^SIMULATION PASSED$'; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1

// File: test/adc_model.sv
// behavioral serial adc that logs the written fields and answers reads from a value table
module adc_model
(
	input  logic rst_n,
	input  logic ad_clk,
	input  logic ad_cfg,
	output logic ad_din
);

	localparam int M_RESET = 0;
	localparam int M_COMM  = 1;
	localparam int M_WRITE = 2;
	localparam int M_READ  = 3;

	// read values loaded by the testbench
	logic [23:0] resp_mem [0:15];
	// written fields in arrival order with comm bytes in the low bits
	logic [23:0] log_mem [0:15];
	int log_cnt = 0;
	int reset_ones = 0;
	logic reset_done = 1'b0;
	int mode = M_RESET;
	int nclk = 0;
	logic [23:0] shift = '0;
	logic [23:0] rd_word = '0;
	logic [3:0] rd_ptr = '0;
	logic cont = 1'b0;
	logic dout = 1'b1;

	assign ad_din = dout;

	task automatic log_field(input logic [23:0] val);
		if (log_cnt < 16)
			log_mem[log_cnt] = val;
		log_cnt++;
	endtask

	task automatic next_word();
		rd_word = resp_mem[rd_ptr];
		rd_ptr = rd_ptr + 1'b1;
	endtask

	always @(posedge ad_clk or negedge rst_n)
	begin
		if (rst_n !== 1'b1)
		begin
			mode = M_RESET;
			reset_ones = 0;
			reset_done = 1'b0;
			nclk = 0;
			log_cnt = 0;
			rd_ptr = '0;
			cont = 1'b0;
		end
		else
		begin
			case (mode)
				M_RESET:
					if (ad_cfg)
						reset_ones++;
					else
					begin
						// first low bit opens the first comm byte
						reset_done = 1'b1;
						shift = '0;
						nclk = 1;
						mode = M_COMM;
					end
				M_COMM:
				begin
					shift = {shift[22:0], ad_cfg};
					nclk++;
					if (nclk == 8)
					begin
						log_field({16'h0, shift[7:0]});
						nclk = 0;
						// bit 6 selects a read and bit 2 continuous read
						if (shift[6])
						begin
							mode = M_READ;
							cont = shift[2];
							next_word();
						end
						else
							mode = M_WRITE;
					end
				end
				M_WRITE:
				begin
					shift = {shift[22:0], ad_cfg};
					nclk++;
					if (nclk == 24)
					begin
						log_field(shift);
						nclk = 0;
						mode = M_COMM;
					end
				end
				default:
				begin
					nclk++;
					if (nclk == 24)
					begin
						nclk = 0;
						if (cont)
							next_word();
						else
							mode = M_COMM;
					end
				end
			endcase
		end
	end

	// data bit changes after the falling clock
	always @(negedge ad_clk)
	begin
		if (rst_n === 1'b1 && mode == M_READ)
			dout <= rd_word[23 - nclk];
	end

endmodule

// File: test/adc_props.sv
// serial engine checks for the idle clock level, a single cycle done and starts only while free
module adc_props
(
	input logic clk_sys,
	input logic rst_n,
	input logic ad_clk,
	input logic cmd_busy,
	input logic cmd_done,
	input logic cmd_start
);

	clk_idle_high: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!cmd_busy |-> ad_clk)
		else $error("ad_clk low while the serial engine is idle");

	done_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cmd_done |=> !cmd_done)
		else $error("cmd_done high for two cycles in a row");

	start_when_free: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cmd_start |-> !cmd_busy)
		else $error("cmd_start issued while the serial engine is busy");

endmodule

bind adc_serial adc_props props0 (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.ad_clk    (ad_clk),
	.cmd_busy  (cmd_busy),
	.cmd_done  (cmd_done),
	.cmd_start (cmd_start)
);

// File: test/tb_adc_top.sv
// testbench running directed tests on the adc controller against a behavioral adc
module tb_adc_top
	import adc_pkg::*;
();

	localparam int INIT_CYCLES   = 40;
	localparam int RESET_BITS    = 32;
	localparam int SAMPLE_PERIOD = 600;
	localparam int AVG_LOG2      = 2;
	localparam int CLK_PERIOD    = 10;
	localparam int AD_PERIOD     = 80;
	localparam int NUM_SAMPLES   = 8;
	localparam int BLOCK_LEN     = 1 << AVG_LOG2;
	localparam int NUM_BLOCKS    = NUM_SAMPLES / BLOCK_LEN;
	// reset clocks, five setup fields and two arming clocks per command
	localparam int CFG_CLOCKS    = RESET_BITS + 8 + 24 + 8 + 24 + 8 + 12;
	localparam int RUN_TIME      = (INIT_CYCLES + 4) * CLK_PERIOD + CFG_CLOCKS * AD_PERIOD
		+ 12 * SAMPLE_PERIOD * CLK_PERIOD;
	localparam int WATCHDOG_TIME = 2 * RUN_TIME;

	logic clk_sys = 1'b0;
	logic rst_n = 1'b0;
	logic ad_clk_in = 1'b1;
	logic ad_din;
	logic ad_clk;
	logic ad_cfg;
	logic ad_vld;
	logic cfg_done;
	logic avg_vld;
	sample_t ad_data;
	sample_t cfg_readback;
	sample_t avg_data;
	integer seed = 32'hab64906e;
	logic [23:0] resp_vals [0:15];
	int smp_cyc [0:NUM_SAMPLES-1];
	logic [23:0] seen_avg [0:NUM_BLOCKS-1];
	int avg_cyc [0:NUM_BLOCKS-1];

	adc_top #(
		.INIT_CYCLES   (INIT_CYCLES),
		.RESET_BITS    (RESET_BITS),
		.SAMPLE_PERIOD (SAMPLE_PERIOD),
		.AVG_LOG2      (AVG_LOG2)
	) dut0 (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ad_clk_in    (ad_clk_in),
		.ad_din       (ad_din),
		.ad_clk       (ad_clk),
		.ad_cfg       (ad_cfg),
		.ad_vld       (ad_vld),
		.ad_data      (ad_data),
		.cfg_done     (cfg_done),
		.cfg_readback (cfg_readback),
		.avg_vld      (avg_vld),
		.avg_data     (avg_data)
	);

	adc_model model0 (
		.rst_n  (rst_n),
		.ad_clk (ad_clk),
		.ad_cfg (ad_cfg),
		.ad_din (ad_din)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// adc bit clock with edges kept apart from the clk_sys edges
	always
	begin
		#2;
		ad_clk_in = 1'b0;
		#(AD_PERIOD / 2);
		ad_clk_in = 1'b1;
		#(AD_PERIOD / 2 - 2);
	end

	initial
	begin
		#(WATCHDOG_TIME);
		$display("ERROR: timeout after %0d time units, the tests did not finish", WATCHDOG_TIME);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic fill_responses();
		logic [31:0] rnd;
		for (int i = 0; i < 16; i++)
		begin
			rnd = $random(seed);
			resp_vals[i] = rnd[23:0];
			model0.resp_mem[i] = rnd[23:0];
		end
	endtask

	task automatic idle_levels();
		compare("ad_clk", ad_clk, 1);
		compare("ad_cfg", ad_cfg, 0);
		compare("ad_vld", ad_vld, 0);
		compare("avg_vld", avg_vld, 0);
		compare("cfg_done", cfg_done, 0);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------

	task automatic idle_after_reset();
		@(posedge clk_sys);
		rst_n <= 1'b0;
		repeat (3)
		begin
			@(negedge clk_sys);
			idle_levels();
			@(posedge clk_sys);
		end
		rst_n <= 1'b1;
		repeat (INIT_CYCLES)
		begin
			@(negedge clk_sys);
			idle_levels();
		end
	endtask

	task automatic reset_bits_seen();
		while (!model0.reset_done)
			@(negedge clk_sys);
		compare("reset_ones >= RESET_BITS", model0.reset_ones >= RESET_BITS, 1);
	endtask

	task automatic readback_matches();
		while (!cfg_done)
			@(negedge clk_sys);
		compare("cfg_readback", cfg_readback.data, resp_vals[0]);
		@(negedge clk_sys);
		compare("cfg_done", cfg_done, 0);
	endtask

	task automatic config_writes_logged();
		while (model0.log_cnt < 4)
			@(negedge clk_sys);
		compare("log_mem[0]", model0.log_mem[0], CFG_COMM_WR_CFG);
		compare("log_mem[1]", model0.log_mem[1], CFG_WORD);
		compare("log_mem[2]", model0.log_mem[2], CFG_COMM_RD_CFG);
		compare("log_mem[3]", model0.log_mem[3], CFG_COMM_CONT_RD);
	endtask

	// also records the averages for the later check
	task automatic samples_in_order();
		int n_smp;
		int n_avg;
		int cyc;
		n_smp = 0;
		n_avg = 0;
		cyc = 0;
		while (n_smp < NUM_SAMPLES || n_avg < NUM_BLOCKS)
		begin
			@(negedge clk_sys);
			cyc++;
			if (ad_vld && n_smp < NUM_SAMPLES)
			begin
				compare("ad_data", ad_data.data, resp_vals[n_smp + 1]);
				smp_cyc[n_smp] = cyc;
				n_smp++;
			end
			if (avg_vld && n_avg < NUM_BLOCKS)
			begin
				seen_avg[n_avg] = avg_data.data;
				avg_cyc[n_avg] = cyc;
				n_avg++;
			end
		end
		// continuous reads add no written field
		compare("log_cnt", model0.log_cnt, 4);
	endtask

	task automatic block_averages();
		logic [31:0] sum;
		for (int b = 0; b < NUM_BLOCKS; b++)
		begin
			sum = 0;
			for (int k = 0; k < BLOCK_LEN; k++)
				sum = sum + resp_vals[b * BLOCK_LEN + k + 1];
			compare("avg_data", seen_avg[b], sum / BLOCK_LEN);
			compare("avg_vld cycle", avg_cyc[b], smp_cyc[b * BLOCK_LEN + BLOCK_LEN - 1] + 1);
		end
	endtask

	task automatic restart_after_reset();
		idle_after_reset();
		reset_bits_seen();
		readback_matches();
		config_writes_logged();
	endtask

	initial
	begin
		fill_responses();
		idle_after_reset();
		reset_bits_seen();
		readback_matches();
		config_writes_logged();
		samples_in_order();
		block_averages();
		restart_after_reset();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: verilog/adc_top.sv
// adc controller top with the sequencer, serial engine and sample averager
module adc_top
	import adc_pkg::*;
#(
	parameter int INIT_CYCLES   = 1048575,
	parameter int RESET_BITS    = 32,
	parameter int SAMPLE_PERIOD = 50000,
	parameter int AVG_LOG2      = 2
)(
	input  logic    clk_sys,
	input  logic    rst_n,
	input  logic    ad_clk_in,
	input  logic    ad_din,
	output logic    ad_clk,
	output logic    ad_cfg,
	output logic    ad_vld,
	output sample_t ad_data,
	output logic    cfg_done,
	output sample_t cfg_readback,
	output logic    avg_vld,
	output sample_t avg_data
);

	ser_cmd_t cmd;
	logic cmd_start;
	logic cmd_busy;
	logic cmd_done;
	sample_t rsp;

	adc_seq #(
		.INIT_CYCLES   (INIT_CYCLES),
		.RESET_BITS    (RESET_BITS),
		.SAMPLE_PERIOD (SAMPLE_PERIOD)
	) seq0 (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.cmd_busy     (cmd_busy),
		.cmd_done     (cmd_done),
		.rsp          (rsp),
		.cmd          (cmd),
		.cmd_start    (cmd_start),
		.cfg_done     (cfg_done),
		.cfg_readback (cfg_readback),
		.ad_vld       (ad_vld),
		.ad_data      (ad_data)
	);

	adc_serial ser0 (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ad_clk_in (ad_clk_in),
		.ad_din    (ad_din),
		.cmd       (cmd),
		.cmd_start (cmd_start),
		.ad_clk    (ad_clk),
		.ad_cfg    (ad_cfg),
		.cmd_busy  (cmd_busy),
		.cmd_done  (cmd_done),
		.rsp       (rsp)
	);

	sample_avg #(
		.AVG_LOG2 (AVG_LOG2)
	) avg0 (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.in_vld   (ad_vld),
		.in_data  (ad_data),
		.avg_vld  (avg_vld),
		.avg_data (avg_data)
	);

endmodule

// File: verilog/sample_avg.sv
// block averager giving the mean of each group of 2^AVG_LOG2 unsigned samples
module sample_avg
	import adc_pkg::*;
#(
	parameter int AVG_LOG2 = 2
)(
	input  logic    clk_sys,
	input  logic    rst_n,
	input  logic    in_vld,
	input  sample_t in_data,
	output logic    avg_vld,
	output sample_t avg_data
);

	localparam int ACC_W = SAMPLE_W + AVG_LOG2;

	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] sum;
	logic [AVG_LOG2-1:0] cnt;
	logic block_end;

	// sum can not overflow with the extra AVG_LOG2 bits
	assign sum       = acc + ACC_W'(in_data.data);
	assign block_end = in_vld && (&cnt);

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			acc     <= '0;
			cnt     <= '0;
			avg_vld <= 1'b0;
		end
		else
		begin
			avg_vld <= block_end;
			if (in_vld)
			begin
				cnt <= cnt + 1'b1;
				acc <= block_end ? '0 : sum;
			end
		end
	end

	// divide by the block length
	always_ff @(posedge clk_sys)
	begin
		if (block_end)
			avg_data.data <= sum[ACC_W-1:AVG_LOG2];
	end

endmodule
